/* hdl/fetch_pkg.sv */
package fetch_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int INSTR_W = 16; // Program word
	localparam int ADDR_W = 12; // Program counter
	localparam int SEL_W = 4; // Register select field

	// Low field of a CALL word that turns it into RET
	localparam logic [ADDR_W-1:0] RET_FIELD = '1;

	//////////////////////////////////////////////////
	// Opcode classes, top nibble of the word
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		NULL_OP = 4'd0,
		ALU = 4'd1,
		LOG = 4'd2,
		SHF = 4'd3,
		SYS = 4'd4,
		LOAD = 4'd5, // Also STORE
		SET = 4'd6, // Next word is an immediate
		MOVE = 4'd7,
		PUSH = 4'd8,
		JZ = 4'd9,
		JNZ = 4'd10,
		JP = 4'd11,
		JMP = 4'd12,
		IN_OP = 4'd13, // Also OUT
		CALL = 4'd14, // Also RET
		HALT = 4'd15
	} opcode_e;

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////

	// Word handed to the next stage
	typedef struct packed {
		logic [INSTR_W-1:0] instr;
		logic [SEL_W-1:0] in1_sel;
		logic [SEL_W-1:0] in0_sel;
	} issue_t;

	// Strobe from the stage that evaluates the condition
	typedef struct packed {
		logic valid;
		logic taken;
	} jump_resolve_t;

	// Decoder result for the held word
	typedef struct packed {
		opcode_e op;
		logic [SEL_W-1:0] in1_sel;
		logic [SEL_W-1:0] in0_sel;
		logic load_stall; // LOAD with zero low nibble
		logic is_jump;
		logic is_call;
		logic is_ret;
		logic is_set;
		logic is_halt;
		logic jump_back; // Bit 8, subtract offset
		logic [7:0] jump_offset; // Bits 7:0
		logic [ADDR_W-1:0] call_target;
	} decode_t;

endpackage

/* hdl/opcode_decode.sv */
module opcode_decode
	import fetch_pkg::*;
(
	input logic [INSTR_W-1:0] instr_i,
	output decode_t dec_o
);

	//////////////////////////////////////////////////
	// Class and select decode
	//////////////////////////////////////////////////

	always_comb
	begin
		dec_o = '0;
		dec_o.op = opcode_e'(instr_i[15:12]);
		dec_o.jump_back = instr_i[8]; // Direction of relative jump
		dec_o.jump_offset = instr_i[7:0];
		dec_o.call_target = instr_i[ADDR_W-1:0]; // Absolute target

		case (dec_o.op)
			ALU, LOG:
			begin
				dec_o.in1_sel = {1'b0, instr_i[8:6]};
				dec_o.in0_sel = {1'b0, instr_i[5:3]};
			end
			SHF:
			begin
				dec_o.in1_sel = instr_i[11:8]; // Same register on both ports
				dec_o.in0_sel = instr_i[11:8];
			end
			LOAD:
			begin
				dec_o.in1_sel = instr_i[11:8];
				dec_o.in0_sel = instr_i[7:4];
				dec_o.load_stall = (instr_i[3:0] == 4'h0); // Result needed by next word
			end
			MOVE, PUSH, IN_OP:
			begin
				dec_o.in1_sel = instr_i[11:8];
				dec_o.in0_sel = instr_i[7:4];
			end
			JZ, JNZ, JP, JMP:
			begin
				dec_o.in1_sel = {1'b0, instr_i[11:9]}; // Condition register
				dec_o.is_jump = 1'b1;
			end
			SET:
			begin
				dec_o.is_set = 1'b1;
			end
			CALL:
			begin
				if (instr_i[ADDR_W-1:0] == RET_FIELD)
				begin
					dec_o.is_ret = 1'b1;
				end
				else
				begin
					dec_o.is_call = 1'b1;
				end
			end
			HALT:
			begin
				dec_o.is_halt = 1'b1;
			end
			default:
			begin
				dec_o.in1_sel = '0; // NULL and SYS carry no selects
				dec_o.in0_sel = '0;
			end
		endcase
	end

endmodule

/* hdl/fetch_sequencer.sv */
module fetch_sequencer
	import fetch_pkg::*;
(
	input logic clk,
	input logic arst_n_i,
	input logic [INSTR_W-1:0] opcode_i,
	input decode_t dec_i,
	input jump_resolve_t jump_resolve_i,
	input logic wake_i,
	input logic [ADDR_W-1:0] stack_top_i,
	output logic [INSTR_W-1:0] held_instr_o,
	output logic push_o,
	output logic pop_o,
	output logic [ADDR_W-1:0] push_addr_o,
	output logic [ADDR_W-1:0] fetch_addr_o,
	output issue_t issue_o
);

	typedef enum logic [1:0] {
		ST_RUN = 2'd0,
		ST_JWAIT = 2'd1, // Jump issued and waiting for resolution
		ST_HALT = 2'd2
	} seq_state_e;

	seq_state_e state_q;
	seq_state_e state_d;
	logic [ADDR_W-1:0] pc_q; // Address of the word on opcode_i
	logic [ADDR_W-1:0] pc_d;
	logic [ADDR_W-1:0] pc_plus1;
	logic [ADDR_W-1:0] jump_target;
	logic [INSTR_W-1:0] held_q; // Word at pc_q - 1, or a bubble
	logic [INSTR_W-1:0] held_d;
	issue_t issue_q;
	issue_t issue_d;
	issue_t held_issue;

	//////////////////////////////////////////////////
	// Address arithmetic
	//////////////////////////////////////////////////

	assign pc_plus1 = pc_q + ADDR_W'(1);

	// pc_q already points one past the held jump
	assign jump_target = dec_i.jump_back ? (pc_q - ADDR_W'(dec_i.jump_offset))
		: (pc_q + ADDR_W'(dec_i.jump_offset));

	assign held_issue = '{instr: held_q, in1_sel: dec_i.in1_sel, in0_sel: dec_i.in0_sel};

	// Stack is touched only when the word is actually executed
	assign push_o = (state_q == ST_RUN) && dec_i.is_call;
	assign pop_o = (state_q == ST_RUN) && dec_i.is_ret;
	assign push_addr_o = pc_q; // Return lands after the CALL

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		pc_d = pc_q;
		held_d = held_q;
		issue_d = '0; // NULL unless a word goes out

		case (state_q)
			ST_RUN:
			begin
				issue_d = held_issue;
				if (dec_i.is_halt)
				begin
					issue_d = '0; // HALT never reaches the next stage
					state_d = ST_HALT;
				end
				else if (dec_i.is_jump)
				begin
					state_d = ST_JWAIT; // Jump stays held for its offset
				end
				else if (dec_i.load_stall)
				begin
					held_d = '0; // One bubble then refetch of the same address
				end
				else if (dec_i.is_set)
				begin
					pc_d = pc_plus1; // Skip the immediate
					held_d = '0;
				end
				else if (dec_i.is_call)
				begin
					pc_d = dec_i.call_target;
					held_d = '0;
				end
				else if (dec_i.is_ret)
				begin
					pc_d = stack_top_i;
					held_d = '0;
				end
				else
				begin
					pc_d = pc_plus1;
					held_d = opcode_i;
				end
			end
			ST_JWAIT:
			begin
				if (jump_resolve_i.valid)
				begin
					state_d = ST_RUN;
					if (jump_resolve_i.taken)
					begin
						pc_d = jump_target;
						held_d = '0; // Target word not fetched yet
					end
					else
					begin
						pc_d = pc_plus1; // Fall-through word is on opcode_i
						held_d = opcode_i;
					end
				end
			end
			ST_HALT:
			begin
				if (wake_i)
				begin
					state_d = ST_RUN;
					pc_d = pc_plus1;
					held_d = opcode_i; // Word after the HALT
				end
			end
			default:
			begin
				state_d = ST_RUN;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(negedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_RUN;
			pc_q <= '0;
			held_q <= '0;
			issue_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			pc_q <= pc_d;
			held_q <= held_d;
			issue_q <= issue_d; // Result step
		end
	end

	assign held_instr_o = held_q;
	assign fetch_addr_o = pc_q;
	assign issue_o = issue_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_resolve_only_in_wait: assert property (@(negedge clk) disable iff (!arst_n_i)
		jump_resolve_i.valid |-> (state_q == ST_JWAIT))
		else $error("jump resolve strobe outside jump wait");

	// Covers the edge that enters the halt as well as the edges spent in it
	a_halt_addr_stable: assert property (@(negedge clk) disable iff (!arst_n_i)
		(state_q == ST_HALT) |-> $stable(fetch_addr_o))
		else $error("fetch address moved while halted");

endmodule

/* hdl/return_stack.sv */
module return_stack
	import fetch_pkg::*;
#(
	parameter int STACK_DEPTH = 128
)
(
	input logic clk,
	input logic arst_n_i,
	input logic push_i,
	input logic pop_i,
	input logic [ADDR_W-1:0] push_addr_i,
	output logic [ADDR_W-1:0] top_o
);

	localparam int PTR_W = $clog2(STACK_DEPTH);
	localparam int CNT_W = PTR_W + 1; // Holds 0 to STACK_DEPTH

	logic [ADDR_W-1:0] stack_mem [STACK_DEPTH];
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] top_idx;
	logic empty;
	logic full;

	assign empty = (count_q == '0);
	assign full = (count_q == CNT_W'(STACK_DEPTH));
	assign top_idx = count_q - CNT_W'(1);

	// Empty stack sends a RET to address 0
	assign top_o = empty ? '0 : stack_mem[top_idx[PTR_W-1:0]];

	//////////////////////////////////////////////////
	// Depth counter, saturating both ways
	//////////////////////////////////////////////////

	always_ff @(negedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			count_q <= '0;
		end
		else if (push_i && !full)
		begin
			count_q <= count_q + CNT_W'(1);
		end
		else if (pop_i && !empty)
		begin
			count_q <= top_idx;
		end
	end

	always_ff @(negedge clk)
	begin
		if (push_i && !full)
		begin
			stack_mem[count_q[PTR_W-1:0]] <= push_addr_i; // Write above current top
		end
	end

	a_no_push_pop: assert property (@(negedge clk) disable iff (!arst_n_i)
		!(push_i && pop_i))
		else $error("push and pop in the same cycle");

	a_no_overflow: assert property (@(negedge clk) disable iff (!arst_n_i)
		push_i |-> !full)
		else $error("CALL nesting exceeds stack depth");

endmodule

/* hdl/fetch_stage.sv */
module fetch_stage
	import fetch_pkg::*;
#(
	parameter int STACK_DEPTH = 128
)
(
	input logic clk,
	input logic arst_n_i,
	input logic [INSTR_W-1:0] opcode_i,
	input jump_resolve_t jump_resolve_i,
	input logic wake_i,
	output logic [ADDR_W-1:0] fetch_addr_o,
	output issue_t issue_o
);

	logic [INSTR_W-1:0] held_instr;
	decode_t dec;
	logic push;
	logic pop;
	logic [ADDR_W-1:0] push_addr;
	logic [ADDR_W-1:0] stack_top;

	opcode_decode i_opcode_decode (
		.instr_i (held_instr),
		.dec_o (dec)
	);

	fetch_sequencer i_fetch_sequencer (
		.clk (clk),
		.arst_n_i (arst_n_i),
		.opcode_i (opcode_i),
		.dec_i (dec),
		.jump_resolve_i (jump_resolve_i),
		.wake_i (wake_i),
		.stack_top_i (stack_top),
		.held_instr_o (held_instr),
		.push_o (push),
		.pop_o (pop),
		.push_addr_o (push_addr),
		.fetch_addr_o (fetch_addr_o),
		.issue_o (issue_o)
	);

	return_stack #(
		.STACK_DEPTH (STACK_DEPTH)
	) i_return_stack (
		.clk (clk),
		.arst_n_i (arst_n_i),
		.push_i (push),
		.pop_i (pop),
		.push_addr_i (push_addr),
		.top_o (stack_top)
	);

endmodule

/* testbench/fetch_stage_tasks.svh */
`ifndef FETCH_STAGE_TASKS_SVH
`define FETCH_STAGE_TASKS_SVH

//////////////////////////////////////////////////
// Random words
//////////////////////////////////////////////////

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic int rand_range(int lo, int hi);
	logic [31:0] r;
	r = lcg_next();
	return lo + (int'({17'b0, r[30:16]}) % (hi - lo + 1));
endfunction

// One of ALU, LOG, SHF, MOVE, PUSH and IN with random fields
function automatic logic [15:0] class_word(int k);
	logic [3:0] op;
	logic [31:0] r;
	case (k)
		0: op = 4'd1;
		1: op = 4'd2;
		2: op = 4'd3;
		3: op = 4'd7;
		4: op = 4'd8;
		default: op = 4'd13;
	endcase
	r = lcg_next();
	return {op, r[27:16]};
endfunction

// Random pick among the plain classes
function automatic logic [15:0] plain_word();
	return class_word(rand_range(0, 5));
endfunction

function automatic logic [15:0] jump_word(logic [3:0] op, logic back, logic [7:0] off);
	logic [31:0] r;
	r = lcg_next();
	return {op, r[18:16], back, off};
endfunction

// Selects from the register fields of each class
function automatic issue_t expected_issue(logic [15:0] w);
	issue_t e;
	e = '0;
	e.instr = w;
	case (w[15:12])
		4'd1, 4'd2:
		begin
			e.in1_sel = {1'b0, w[8:6]};
			e.in0_sel = {1'b0, w[5:3]};
		end
		4'd3:
		begin
			e.in1_sel = w[11:8];
			e.in0_sel = w[11:8];
		end
		4'd5, 4'd7, 4'd8, 4'd13:
		begin
			e.in1_sel = w[11:8];
			e.in0_sel = w[7:4];
		end
		4'd9, 4'd10, 4'd11, 4'd12: e.in1_sel = {1'b0, w[11:9]};
		default: e.in1_sel = '0;
	endcase
	return e;
endfunction

//////////////////////////////////////////////////
// Software walk and issue checker
//////////////////////////////////////////////////

task automatic walk_program();
	logic [11:0] pc;
	logic [11:0] stk [16];
	logic [15:0] w;
	int sp;
	int ti;
	pc = '0;
	sp = 0;
	ti = 0;
	for (int step = 0; step < 64; step++)
	begin
		w = prog_mem[pc];
		if (w[15:12] == 4'd0)
			break; // End of program
		if (w[15:12] != 4'd15)
			exp_q.push_back(expected_issue(w)); // HALT stays internal
		if (w[15:12] == 4'd6)
			pc = pc + 12'd2; // Skip immediate
		else if (w[15:12] >= 4'd9 && w[15:12] <= 4'd12)
		begin
			if (taken_q[ti])
				pc = w[8] ? pc + 12'd1 - 12'(w[7:0]) : pc + 12'd1 + 12'(w[7:0]);
			else
				pc = pc + 12'd1;
			ti++;
		end
		else if (w[15:12] == 4'd14 && w[11:0] == 12'hFFF)
		begin
			if (sp == 0)
				pc = '0;
			else
			begin
				sp--;
				pc = stk[sp];
			end
		end
		else if (w[15:12] == 4'd14)
		begin
			stk[sp] = pc + 12'd1;
			sp++;
			pc = w[11:0];
		end
		else
			pc = pc + 12'd1;
	end
endtask

// Compare each non-NULL issue word, resolve jumps, hold a HALT for a while
task automatic run_program(int halt_after, int halt_cycles);
	int idx;
	int guard;
	int delay;
	logic [11:0] halt_addr;
	logic [15:0] w;
	walk_program();
	idx = 0;
	guard = 0;
	while (idx < exp_q.size() && guard < 300)
	begin
		@(posedge clk);
		guard++;
		w = issue.instr;
		if (w != '0)
		begin
			checks++;
			assert (issue == exp_q[idx]) else
			begin
				errors++;
				$display("Error at %0d ns: issue %h, expected %h", $time, issue, exp_q[idx]);
			end
			idx++;
			#10 wake_i = 1'b0;
			if (w[15:12] >= 4'd9 && w[15:12] <= 4'd12)
			begin
				delay = rand_range(1, 6);
				for (int d = 0; d < delay; d++)
				begin
					@(posedge clk);
					checks++;
					assert (issue.instr == '0) else
					begin
						errors++;
						$display("Error at %0d ns: word %h issued during jump wait",
							$time, issue.instr);
					end
				end
				#10 jump_resolve_i = '{valid: 1'b1, taken: taken_q.pop_front()}; // One-cycle strobe
				@(posedge clk);
				#10 jump_resolve_i = '0;
			end
			if (idx == halt_after)
			begin
				halt_addr = fetch_addr;
				for (int h = 0; h < halt_cycles; h++)
				begin
					@(posedge clk);
					checks++;
					assert (issue.instr == '0 && fetch_addr == halt_addr) else
					begin
						errors++;
						$display("Error at %0d ns: activity while halted", $time);
					end
				end
				#10 wake_i = 1'b1;
			end
		end
	end
	if (idx < exp_q.size())
	begin
		errors++;
		$display("Timeout: only %0d of %0d expected words were issued", idx, exp_q.size());
	end
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic straight_code();
	logic [31:0] r;
	logic [31:0] imm;
	clear_program();
	for (int a = 0; a < 6; a++)
		prog_mem[a] = class_word(a); // Each plain class once
	r = lcg_next();
	prog_mem[6] = {4'd5, r[23:16], 4'h0}; // LOAD with one bubble
	prog_mem[7] = plain_word();
	prog_mem[8] = {4'd6, r[27:16]};
	imm = lcg_next();
	prog_mem[9] = imm[31:16]; // Immediate that is never issued
	prog_mem[10] = plain_word();
	prog_mem[11] = plain_word();
	apply_reset();
	run_program(-1, 0);
endtask

task automatic jump_outcomes();
	clear_program();
	for (int a = 0; a < 14; a++)
		prog_mem[a] = plain_word();
	prog_mem[1] = jump_word(4'd12, 1'b0, 8'd3); // Forward to 5
	prog_mem[6] = jump_word(4'd9, 1'b0, 8'd17);
	prog_mem[9] = jump_word(4'd11, 1'b0, 8'd2); // Forward to 12
	prog_mem[12] = jump_word(4'd10, 1'b1, 8'd3); // Back to 10
	taken_q.push_back(1'b1);
	taken_q.push_back(1'b0);
	taken_q.push_back(1'b1);
	taken_q.push_back(1'b1);
	taken_q.push_back(1'b0);
	apply_reset();
	run_program(-1, 0);
endtask

task automatic nested_calls();
	clear_program();
	prog_mem[0] = plain_word();
	prog_mem[1] = 16'hE014; // CALL 20
	prog_mem[2] = plain_word();
	prog_mem[20] = plain_word();
	prog_mem[21] = 16'hE01E; // CALL 30
	prog_mem[22] = plain_word();
	prog_mem[23] = 16'hEFFF;
	prog_mem[30] = plain_word();
	prog_mem[31] = 16'hEFFF;
	apply_reset();
	run_program(-1, 0);
endtask

task automatic halt_until_wake();
	logic [31:0] r;
	clear_program();
	r = lcg_next();
	prog_mem[0] = plain_word();
	prog_mem[1] = plain_word();
	prog_mem[2] = {4'd15, r[27:16]};
	prog_mem[3] = plain_word();
	prog_mem[4] = plain_word();
	apply_reset();
	run_program(2, rand_range(3, 10));
	wake_i = 1'b0;
endtask

`endif

/* testbench/fetch_stage_tb.sv */
module fetch_stage_tb
	import fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arst_n_i;
	logic [INSTR_W-1:0] opcode_i;
	jump_resolve_t jump_resolve_i;
	logic wake_i;
	logic [ADDR_W-1:0] fetch_addr;
	issue_t issue;

	logic [INSTR_W-1:0] prog_mem [4096]; // Asynchronous program memory
	logic [31:0] lcg_state;
	int errors;
	int checks;
	issue_t exp_q [$]; // Expected non-NULL issue order
	logic taken_q [$]; // Jump outcomes in execution order

	fetch_stage #(
		.STACK_DEPTH (128)
	) i_fetch_stage (
		.clk (clk),
		.arst_n_i (arst_n_i),
		.opcode_i (opcode_i),
		.jump_resolve_i (jump_resolve_i),
		.wake_i (wake_i),
		.fetch_addr_o (fetch_addr),
		.issue_o (issue)
	);

	assign opcode_i = prog_mem[fetch_addr];

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	`include "fetch_stage_tasks.svh"

	//////////////////////////////////////////////////
	// Reset and program setup
	//////////////////////////////////////////////////

	task automatic clear_program();
		for (int a = 0; a < 4096; a++)
		begin
			prog_mem[a] = '0;
		end
		taken_q.delete();
		exp_q.delete();
	endtask

	task automatic apply_reset();
		arst_n_i = 1'b0;
		repeat (5)
		begin
			@(posedge clk);
			checks++;
			assert (issue == '0 && fetch_addr == '0) else
			begin
				errors++;
				$display("Error at %0d ns: outputs not cleared during reset", $time);
			end
		end
		#10 arst_n_i = 1'b1;
		#1;
		checks++;
		assert (issue == '0 && fetch_addr == '0) else
		begin
			errors++;
			$display("Error at %0d ns: outputs not cleared after reset", $time);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		arst_n_i = 1'b0;
		jump_resolve_i = '0;
		wake_i = 1'b0;
		lcg_state = 32'd86;
		errors = 0;
		checks = 0;
		clear_program();

		straight_code();
		jump_outcomes();
		nested_calls();
		halt_until_wake();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* fetch_stage.f */
+incdir+testbench
hdl/fetch_pkg.sv
hdl/opcode_decode.sv
hdl/fetch_sequencer.sv
hdl/return_stack.sv
hdl/fetch_stage.sv
testbench/fetch_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f fetch_stage.f \
	--top-module fetch_stage_tb -o fetch_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fetch_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Everything OK" "$LOG"; then
	exit 0
fi
exit 1
